// File: list.f
source/servo_pkg.sv
source/servo_regs.sv
source/servo_width_ramp.sv
source/servo_frame_gen.sv
source/servo_ctrl_top.sv
tb/servo_tb.sv

// File: run.sh
#!/bin/sh
# build and run the servo testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module servo_tb -f list.f -o Vservo_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vservo_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

# the log decides the verdict
if grep -q "TESTS FAILED" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
   echo "simulation ended without a verdict"
   exit 1
fi

exit 0

// File: source/servo_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module servo_ctrl_top
   import servo_pkg::*;
(
   input  logic        CLK,
   input  logic        arst_n,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        servo
);

   // register block to pulse logic
   servo_cfg_t cfg;
   // applied width, also read back through status
   width_t     width;
   // frame boundary strobe for the ramp
   logic       frame_end;

   servo_regs u_regs (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .width   (width),
      .cfg     (cfg)
   );

   servo_width_ramp u_ramp (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .cfg       (cfg),
      .frame_end (frame_end),
      .width     (width)
   );

   servo_frame_gen u_frame (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .cfg       (cfg),
      .width     (width),
      .servo     (servo),
      .frame_end (frame_end)
   );

endmodule

`default_nettype wire

// File: source/servo_frame_gen.sv
`timescale 1ns/1ps
`default_nettype none

module servo_frame_gen
   import servo_pkg::*;
(
   input  logic       CLK,
   input  logic       arst_n,
   input  servo_cfg_t cfg,
   input  width_t     width,
   output logic       servo,
   output logic       frame_end
);

   // tick position inside the frame, wide enough for high plus low
   logic [WIDTH_W:0] pos;
   logic             running;
   logic             first_tick;

   // phase lengths latched on the first tick
   width_t           width_q;
   width_t           low_q;

   // phase lengths in force this tick
   width_t           cur_width;
   width_t           cur_low;
   logic [WIDTH_W:0] frame_len;

   // frames advance only while moving
   assign running = cfg.enable && ((cfg.dir == CW) || (cfg.dir == CCW));

   assign first_tick = (pos == '0);

   // first tick uses live values so the output rises at once
   assign cur_width = first_tick ? width : width_q;
   assign cur_low   = first_tick ? cfg.low_time : low_q;
   assign frame_len = {1'b0, cur_width} + {1'b0, cur_low};

   // high phase covers the first cur_width ticks
   assign servo = running && (pos < {1'b0, cur_width});

   // last low tick, or the only tick of an empty frame
   assign frame_end = running && ((pos + 1'b1) >= frame_len);

   // position counter
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         pos <= '0;
      end else if (!cfg.enable) begin
         // disable abandons the frame
         pos <= '0;
      end else if (running) begin
         if (frame_end) begin
            pos <= '0;
         end else begin
            pos <= pos + 1'b1;
         end
      end
      // stop and reserved hold the position
   end

   // capture the frame's lengths
   always_ff @(posedge CLK) begin
      if (running && first_tick) begin
         width_q <= width;
         low_q   <= cfg.low_time;
      end
   end

   a_quiet_when_disabled: assert property (
      @(posedge CLK) disable iff (!arst_n)
      !cfg.enable |-> !servo
   );

endmodule

`default_nettype wire

// File: source/servo_pkg.sv
`default_nettype none

package servo_pkg;

   // every pulse and time quantity is a 16-bit tick count
   localparam int WIDTH_W = 16;

   typedef logic [WIDTH_W-1:0] width_t;

   // pulse width limits in CLK ticks
   localparam width_t MIN_PULSE    = 16'd500;
   localparam width_t MAX_PULSE    = 16'd2500;
   // width change per frame boundary
   localparam width_t STEP_PULSE   = 16'd10;
   // low phase length after reset
   localparam width_t LOW_TIME_RST = 16'd15000;

   // RSVD is decoded like STOP
   typedef enum logic [1:0] {
      STOP = 2'd0,
      CW   = 2'd1,
      CCW  = 2'd2,
      RSVD = 2'd3
   } dir_t;

   // APB byte offsets
   localparam logic [3:0] ADDR_CTRL   = 4'h0;
   localparam logic [3:0] ADDR_OVR    = 4'h4;
   localparam logic [3:0] ADDR_LOW    = 4'h8;
   localparam logic [3:0] ADDR_STATUS = 4'hC;

   // control register layout, enable in bit 0
   typedef struct packed {
      logic [27:0] pad;
      logic        max_enable;
      dir_t        dir;
      logic        enable;
   } ctrl_word_t;

   // width registers use the low half only
   typedef struct packed {
      logic [15:0] pad;
      width_t      value;
   } width_word_t;

   // one bus word, seen as control fields or as a width
   typedef union packed {
      ctrl_word_t  ctrl;
      width_word_t wid;
   } reg_word_u;

   // register block outputs to the pulse logic
   typedef struct packed {
      logic   enable;
      dir_t   dir;
      logic   max_enable;
      width_t ovr_width;
      width_t low_time;
   } servo_cfg_t;

endpackage

`default_nettype wire

// File: source/servo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module servo_regs
   import servo_pkg::*;
(
   input  logic        CLK,
   input  logic        arst_n,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   input  width_t      width,
   output servo_cfg_t  cfg
);

   // decoded views of the bus words
   reg_word_u  wr_word;
   reg_word_u  rd_word;

   logic       access;
   logic       addr_ok;
   logic       illegal;

   // control state
   logic       enable_q;
   dir_t       dir_q;
   logic       max_en_q;
   width_t     ovr_q;
   width_t     low_q;

   // second cycle of a transfer
   assign access = psel && penable;

   // only the four word offsets are mapped
   always_comb begin
      case (paddr)
         ADDR_CTRL,
         ADDR_OVR,
         ADDR_LOW,
         ADDR_STATUS: addr_ok = 1'b1;
         default:     addr_ok = 1'b0;
      endcase
   end

   // status is read only
   assign illegal = !addr_ok || (pwrite && (paddr == ADDR_STATUS));

   // no wait states, every access completes in one access cycle
   assign pready  = 1'b1;
   assign pslverr = access && illegal;

   assign wr_word = pwdata;

   // register writes, visible on cfg the cycle after the access phase
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         enable_q <= 1'b0;
         dir_q    <= STOP;
         max_en_q <= 1'b0;
         ovr_q    <= MIN_PULSE;
         low_q    <= LOW_TIME_RST;
      end else if (access && pwrite && !illegal) begin
         case (paddr)
            ADDR_CTRL: begin
               enable_q <= wr_word.ctrl.enable;
               dir_q    <= wr_word.ctrl.dir;
               max_en_q <= wr_word.ctrl.max_enable;
            end
            ADDR_OVR: begin
               ovr_q <= wr_word.wid.value;
            end
            ADDR_LOW: begin
               low_q <= wr_word.wid.value;
            end
            default: begin
            end
         endcase
      end
   end

   // read mux, unmapped offsets read as zero
   always_comb begin
      rd_word = '0;
      case (paddr)
         ADDR_CTRL: begin
            rd_word.ctrl.enable     = enable_q;
            rd_word.ctrl.dir        = dir_q;
            rd_word.ctrl.max_enable = max_en_q;
         end
         ADDR_OVR: begin
            rd_word.wid.value = ovr_q;
         end
         ADDR_LOW: begin
            rd_word.wid.value = low_q;
         end
         // width the next frame will sample
         ADDR_STATUS: begin
            rd_word.wid.value = width;
         end
         default: begin
         end
      endcase
   end

   assign prdata = rd_word;

   assign cfg = '{
      enable:     enable_q,
      dir:        dir_q,
      max_enable: max_en_q,
      ovr_width:  ovr_q,
      low_time:   low_q
   };

   // error response only in the access phase
   a_pslverr_access: assert property (
      @(posedge CLK) disable iff (!arst_n)
      pslverr |-> (psel && penable)
   );

endmodule

`default_nettype wire

// File: source/servo_width_ramp.sv
`timescale 1ns/1ps
`default_nettype none

module servo_width_ramp
   import servo_pkg::*;
(
   input  logic       CLK,
   input  logic       arst_n,
   input  servo_cfg_t cfg,
   input  logic       frame_end,
   output width_t     width
);

   // ramped width, kept between the limits
   width_t           ramp_q;
   width_t           ramp_next;
   // one extra bit so the upward step cannot wrap
   logic [WIDTH_W:0] up_sum;
   logic             ovr_active;

   // software width wins only while enabled and narrowing
   assign ovr_active = cfg.enable && cfg.max_enable && (cfg.dir == CCW);

   assign up_sum = {1'b0, ramp_q} + {1'b0, STEP_PULSE};

   // next frame's ramped width by direction
   always_comb begin
      ramp_next = ramp_q;
      case (cfg.dir)
         CW: begin
            // widen, clamp at the upper limit
            if (up_sum > {1'b0, MAX_PULSE}) begin
               ramp_next = MAX_PULSE;
            end else begin
               ramp_next = up_sum[WIDTH_W-1:0];
            end
         end
         CCW: begin
            // narrow, clamp at the lower limit
            // ramp holds during override
            if (!cfg.max_enable) begin
               if (ramp_q < (MIN_PULSE + STEP_PULSE)) begin
                  ramp_next = MIN_PULSE;
               end else begin
                  ramp_next = ramp_q - STEP_PULSE;
               end
            end
         end
         // stop and reserved hold
         default: begin
            ramp_next = ramp_q;
         end
      endcase
   end

   // step once per frame boundary
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         ramp_q <= MIN_PULSE;
      end else if (!cfg.enable) begin
         // disabled servo restarts from the lower limit
         ramp_q <= MIN_PULSE;
      end else if (frame_end) begin
         ramp_q <= ramp_next;
      end
   end

   // applied width, sampled by the frame generator at frame start
   assign width = ovr_active ? cfg.ovr_width : ramp_q;

   a_ramp_in_range: assert property (
      @(posedge CLK) disable iff (!arst_n)
      (ramp_q >= MIN_PULSE) && (ramp_q <= MAX_PULSE)
   );

endmodule

`default_nettype wire

// File: tb/servo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module servo_tb
   import servo_pkg::*;
();

   logic        CLK;
   logic        arst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        servo;

   // frame model state
   logic        m_en;
   dir_t        m_dir;
   logic        m_max;
   width_t      m_ovr;
   width_t      m_low;
   width_t      m_ramp;
   width_t      exp_hi;
   width_t      exp_lo;

   // run monitor
   int          hi_runs[$];
   int          lo_runs[$];
   int          run_len;
   logic        servo_d;
   logic        track_low;

   logic [31:0] lcg_state;
   int          cycle_count;
   int          cycle_limit;
   int          n_cw, n_ccw, n_up, n_ovr, n_resume, n_restart, n_stop;
   width_t      low_cw, low_re, ovr_w;
   logic [31:0] rdata;
   logic        err;
   reg_word_u   word;

   servo_ctrl_top uut (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .servo   (servo)
   );

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // abort once the planned frames should long be over
   always @(posedge CLK) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: servo frames did not finish within %0d cycles", cycle_limit);
         $display("TESTS FAILED");
         $fatal(1, "run stopped by timeout");
      end
   end

   // measure every high run and every low run that follows a high run
   always @(negedge CLK) begin
      if (servo && !servo_d) begin
         if (track_low) begin
            lo_runs.push_back(run_len);
         end
         run_len = 1;
      end else if (!servo && servo_d) begin
         hi_runs.push_back(run_len);
         track_low = 1'b1;
         run_len = 1;
      end else begin
         run_len = run_len + 1;
      end
      servo_d = servo;
   end

   function automatic int unsigned next_random(input int unsigned span);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return (lcg_state >> 8) % span;
   endfunction

   // ramp rule at a frame boundary
   function automatic width_t step_ramp(input width_t r);
      int v;
      v = int'(r);
      if (m_dir == CW) begin
         v = v + int'(STEP_PULSE);
         if (v > int'(MAX_PULSE)) v = int'(MAX_PULSE);
      end else if ((m_dir == CCW) && !m_max) begin
         v = v - int'(STEP_PULSE);
         if (v < int'(MIN_PULSE)) v = int'(MIN_PULSE);
      end
      return width_t'(v);
   endfunction

   // override replaces the ramp only in CCW
   function automatic width_t applied_width();
      return (m_en && m_max && (m_dir == CCW)) ? m_ovr : m_ramp;
   endfunction

   function automatic ctrl_word_t model_ctrl();
      ctrl_word_t c;
      c = '0;
      c.enable     = m_en;
      c.dir        = m_dir;
      c.max_enable = m_max;
      return c;
   endfunction

   task automatic compare_width(input string name, input width_t exp, input width_t act);
      if (act !== exp) begin
         $display("ERROR %s expected %0d actual %0d", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "width mismatch in %s", name);
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR %s expected %b actual %b", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "bit mismatch in %s", name);
      end
   endtask

   task automatic compare_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
      if (act !== exp) begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "control mismatch in %s", name);
      end
   endtask

   // setup cycle, one access cycle, sampled mid access phase
   task automatic transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rd, output logic slverr);
      @(posedge CLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge CLK);
      penable <= 1'b1;
      @(negedge CLK);
      rd     = prdata;
      slverr = pslverr;
      // zero wait states, the access phase always completes
      compare_bit("apb pready", 1'b1, pready);
      @(posedge CLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_ctrl(input string name, input logic en, input dir_t dir, input logic mx);
      logic [31:0] rd;
      logic        e;
      m_en  = en;
      m_dir = dir;
      m_max = mx;
      transfer(1'b1, ADDR_CTRL, model_ctrl(), rd, e);
      compare_bit(name, 1'b0, e);
   endtask

   task automatic write_width(input string name, input logic [3:0] addr, input width_t w);
      reg_word_u   wd;
      logic [31:0] rd;
      logic        e;
      wd = '0;
      wd.wid.value = w;
      transfer(1'b1, addr, wd, rd, e);
      compare_bit(name, 1'b0, e);
   endtask

   task automatic read_width(input string name, input logic [3:0] addr, input width_t exp);
      reg_word_u rd;
      logic      e;
      transfer(1'b0, addr, '0, rd, e);
      compare_bit(name, 1'b0, e);
      compare_width(name, exp, rd.wid.value);
   endtask

   task automatic flush_runs();
      hi_runs.delete();
      lo_runs.delete();
      track_low = 1'b0;
   endtask

   // one finished frame against the model, then step the model
   task automatic check_frame(input string name);
      int hi;
      int lo;
      while (lo_runs.size() == 0) @(posedge CLK);
      hi = hi_runs.pop_front();
      lo = lo_runs.pop_front();
      compare_width({name, " high"}, exp_hi, width_t'(hi));
      compare_width({name, " low"}, exp_lo, width_t'(lo));
      m_ramp = step_ramp(m_ramp);
      exp_hi = applied_width();
      exp_lo = m_low;
   endtask

   initial begin
      arst_n  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      servo_d = 1'b0;
      run_len = 0;
      track_low = 1'b0;
      cycle_count = 0;
      lcg_state = 32'd745;
      m_en = 1'b0;
      m_dir = STOP;
      m_max = 1'b0;
      m_ovr = MIN_PULSE;
      m_low = LOW_TIME_RST;
      m_ramp = MIN_PULSE;
      // cw and ccw each need 200 steps to reach the far limit
      n_cw      = 204 + next_random(6);
      n_ccw     = 204 + next_random(6);
      n_up      = 5 + next_random(6);
      n_ovr     = 3 + next_random(3);
      n_resume  = 3 + next_random(3);
      n_restart = 3 + next_random(3);
      n_stop    = 10 + next_random(50);
      low_cw    = 8 + next_random(33);
      low_re    = 8 + next_random(33);
      ovr_w     = MIN_PULSE + next_random(MAX_PULSE - MIN_PULSE + 1);
      // longest possible frame for each planned frame, plus bus traffic
      cycle_limit = (int'(MAX_PULSE) + 40) *
                    (n_cw + n_ccw + n_up + n_ovr + n_resume + n_restart) + 2000;
      repeat (4) @(posedge CLK);
      arst_n <= 1'b1;

      // reset values
      transfer(1'b0, ADDR_CTRL, '0, rdata, err);
      word = rdata;
      compare_bit("reset ctrl", 1'b0, err);
      compare_ctrl("reset ctrl", model_ctrl(), word.ctrl);
      read_width("reset low", ADDR_LOW, LOW_TIME_RST);
      read_width("reset status", ADDR_STATUS, MIN_PULSE);
      repeat (10) begin
         @(negedge CLK);
         compare_bit("reset servo", 1'b0, servo);
      end

      // clockwise ramp up to the clamp and beyond
      write_width("cw low", ADDR_LOW, low_cw);
      m_low = low_cw;
      flush_runs();
      write_ctrl("cw enable", 1'b1, CW, 1'b0);
      exp_hi = applied_width();
      exp_lo = m_low;
      repeat (n_cw) check_frame("cw_ramp");

      // counter-clockwise down to the lower clamp
      write_ctrl("ccw dir", 1'b1, CCW, 1'b0);
      repeat (n_ccw) begin
         check_frame("ccw_ramp");
         if (next_random(8) == 0) begin
            read_width("ccw status", ADDR_STATUS, applied_width());
         end
      end

      // lift the ramp first so the held value differs from the limit
      write_ctrl("up dir", 1'b1, CW, 1'b0);
      repeat (n_up) check_frame("override_up");
      write_width("ovr width", ADDR_OVR, ovr_w);
      m_ovr = ovr_w;
      write_ctrl("ovr enable", 1'b1, CCW, 1'b1);
      repeat (n_ovr) check_frame("override");
      write_ctrl("ovr clear", 1'b1, CCW, 1'b0);
      repeat (n_resume) check_frame("override_resume");

      // stop pauses with the line low
      write_ctrl("stop", 1'b1, STOP, 1'b0);
      repeat (n_stop) begin
         @(negedge CLK);
         compare_bit("stop servo", 1'b0, servo);
      end
      write_ctrl("disable", 1'b0, STOP, 1'b0);
      m_ramp = MIN_PULSE;
      @(negedge CLK);
      compare_bit("disable servo", 1'b0, servo);
      read_width("disable status", ADDR_STATUS, MIN_PULSE);
      write_width("restart low", ADDR_LOW, low_re);
      m_low = low_re;
      flush_runs();
      write_ctrl("restart", 1'b1, CW, 1'b0);
      exp_hi = applied_width();
      exp_lo = m_low;
      repeat (n_restart) check_frame("restart");

      // illegal writes leave every register as it was
      write_ctrl("final disable", 1'b0, CW, 1'b0);
      m_ramp = MIN_PULSE;
      transfer(1'b1, ADDR_STATUS, lcg_state, rdata, err);
      compare_bit("illegal status write", 1'b1, err);
      transfer(1'b1, 4'((next_random(4) << 2) | (1 + next_random(3))), lcg_state, rdata, err);
      compare_bit("illegal unmapped write", 1'b1, err);
      transfer(1'b0, ADDR_CTRL, '0, rdata, err);
      word = rdata;
      compare_bit("illegal ctrl", 1'b0, err);
      compare_ctrl("illegal ctrl", model_ctrl(), word.ctrl);
      read_width("illegal ovr", ADDR_OVR, m_ovr);
      read_width("illegal low", ADDR_LOW, m_low);
      read_width("illegal status", ADDR_STATUS, MIN_PULSE);

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
